//--- vga_rx_reg.f
rtl/vga_bus_pkg.sv
rtl/vga_field_pkg.sv
rtl/vga_reg_decode.sv
rtl/vga_event_detect.sv
rtl/vga_ctrl_regs.sv
rtl/vga_irq_status.sv
rtl/vga_dma_ctrl.sv
rtl/vga_read_mux.sv
rtl/vga_rx_reg_top.sv
sim/tb_vga_rx_reg.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
TOP        := tb_vga_rx_reg
RTL_TOP    := vga_rx_reg_top
FILELIST   := vga_rx_reg.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_vga_rx_reg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_rx_reg;

    localparam int NUM_OPS        = 500;
    // Directed reads, then random ops of at most five cycles each
    localparam int PLANNED_CYCLES = 16 + 20 + NUM_OPS * 5;
    localparam int TIMEOUT_CYCLES = 3 * PLANNED_CYCLES;

    logic        clk;
    logic        rst;
    logic [9:0]  wb_adr;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_bstb;
    logic [31:0] wb_dat_w;
    logic [31:0] rx_fifo_data;
    logic [7:0]  rx_state;
    logic [9:0]  line_cnt;
    logic [10:0] fifo_cnt;
    logic        thresh_lvl;
    logic        ovf_lvl;
    logic        full_lvl;
    logic        clear_capture;
    logic        dma_done;
    logic        dma_active;
    logic        dma_clr;

    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        vga_irq;
    logic [15:0] ctrl_word;
    logic [9:0]  thresh_count;
    logic        fifo_flush;
    logic        dma_ena;
    logic        dma_done_irq;

    // Reference model state
    logic        m_ack, m_cap, m_master, m_flush, m_asel, m_apos;
    logic [3:0]  m_int_en;
    logic [3:0]  m_sts;
    logic [1:0]  m_fsize;
    logic [1:0]  m_tsel;
    logic        m_dma_ena, m_done_en, m_done;
    // Input samples, index 0 is the newest
    logic [2:0]  thr_h, frm_h, ovf_h;
    logic [1:0]  full_h;

    integer      seed;
    int          value_errors;
    int          protocol_errors;
    int unsigned cycle_count = 0;

    vga_rx_reg_top #(
        .ADDR_WIDTH (10)
    ) u_dut (
        .WBs_CLK_i        (clk),
        .WBs_RST_i        (rst),
        .WBs_ADR_i        (wb_adr),
        .WBs_CYC_i        (wb_cyc),
        .WBs_BYTE_STB_i   (wb_bstb),
        .WBs_WE_i         (wb_we),
        .WBs_STB_i        (wb_stb),
        .WBs_DAT_i        (wb_dat_w),
        .rx_fifo_data_i   (rx_fifo_data),
        .rx_state_i       (rx_state),
        .rcvd_line_cnt_i  (line_cnt),
        .fifo_count_i     (fifo_cnt),
        .thresh_reached_i (thresh_lvl),
        .overflow_i       (ovf_lvl),
        .fifo_full_i      (full_lvl),
        .clear_capture_i  (clear_capture),
        .dma_done_i       (dma_done),
        .dma_active_i     (dma_active),
        .dma_clr_i        (dma_clr),
        .WBs_DAT_o        (wb_dat_r),
        .WBs_ACK_o        (wb_ack),
        .vga_irq_o        (vga_irq),
        .ctrl_word_o      (ctrl_word),
        .thresh_count_o   (thresh_count),
        .fifo_flush_o     (fifo_flush),
        .dma_ena_o        (dma_ena),
        .dma_done_irq_o   (dma_done_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        begin
            assert (got === exp)
            else
            begin
                value_errors++;
                $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            end
        end
    endtask

    function automatic logic [15:0] model_ctrl_image();
        return {1'b0, m_tsel, m_apos, m_asel, m_fsize, 2'b00, m_int_en,
                m_flush, m_master, m_cap};
    endfunction

    function automatic logic [31:0] predict_read(input logic [9:0] adr);
        case (adr)
            10'(vga_bus_pkg::STATUS_ADDR):      return {28'd0, m_sts};
            10'(vga_bus_pkg::CONTROL_ADDR):     return {16'd0, model_ctrl_image()};
            10'(vga_bus_pkg::FIFO_COUNT_ADDR):  return {21'd0, fifo_cnt};
            10'(vga_bus_pkg::LINE_COUNT_ADDR):  return {22'd0, line_cnt};
            10'(vga_bus_pkg::DMA_CONTROL_ADDR): return {29'd0, m_done, m_done_en, m_dma_ena};
            10'(vga_bus_pkg::DMA_STATUS_ADDR):  return {28'd0, m_tsel, dma_active, m_done};
            10'(vga_bus_pkg::RX_DATA_ADDR):     return rx_fifo_data;
            10'(vga_bus_pkg::DEBUG_ADDR):       return {24'd0, rx_state};
            default:                            return 32'hC0CDEFAC;
        endcase
    endfunction

    // Clock edge in the model, from the inputs held over the last cycle
    task automatic update_model();
        logic       access;
        logic       cwr;
        logic       dwr;
        logic [3:0] ev;
        logic [3:0] wr_val;
        begin
            access = wb_cyc & wb_stb & ~m_ack;
            cwr = access & wb_we & wb_bstb[0] & (wb_adr == 10'(vga_bus_pkg::CONTROL_ADDR));
            dwr = access & wb_we & wb_bstb[0] & (wb_adr == 10'(vga_bus_pkg::DMA_CONTROL_ADDR));
            // Levels set status on the third high sample, FIFO full on the second
            ev[0] = full_h[0] & ~full_h[1];
            ev[1] = ovf_h[1] & ~ovf_h[2];
            ev[2] = thr_h[1] & ~thr_h[2];
            ev[3] = frm_h[1] & ~frm_h[2];
            wr_val = {wb_dat_w[8], wb_dat_w[7], 2'b00};
            for (int i = 0; i < 4; i++)
            begin
                if (ev[i])
                    m_sts[i] = 1'b1;
                else if (cwr)
                    m_sts[i] = wr_val[i];
            end
            if (cwr)
            begin
                m_cap    = wb_dat_w[0];
                m_master = wb_dat_w[1];
                m_flush  = wb_dat_w[2];
                m_int_en = wb_dat_w[6:3];
                m_fsize  = wb_dat_w[10:9];
                m_asel   = wb_dat_w[11];
                m_apos   = wb_dat_w[12];
                m_tsel   = wb_dat_w[14:13];
            end
            else
            begin
                m_flush = 1'b0;
                if (clear_capture)
                    m_cap = 1'b0;
            end
            if (dwr)
                m_dma_ena = wb_dat_w[0];
            else if (dma_clr)
                m_dma_ena = 1'b0;
            if (dwr)
                m_done_en = wb_dat_w[1];
            if (dma_done)
                m_done = 1'b1;
            else if (dwr)
                m_done = wb_dat_w[2];
            thr_h  = {thr_h[1:0], thresh_lvl};
            frm_h  = {frm_h[1:0], rx_state[0]};
            ovf_h  = {ovf_h[1:0], ovf_lvl};
            full_h = {full_h[0], full_lvl};
            m_ack  = access;
        end
    endtask

    task automatic check_outputs();
        logic [9:0] exp_thresh;
        begin
            exp_thresh = (m_tsel == 2'b01) ? 10'd480 : 10'd960;
            check_value("WBs_ACK_o", 32'(wb_ack), 32'(m_ack));
            check_value("fifo_flush_o", 32'(fifo_flush), 32'(m_flush));
            check_value("vga_irq_o", 32'(vga_irq), 32'((|(m_sts & m_int_en)) & m_master));
            check_value("dma_ena_o", 32'(dma_ena), 32'(m_dma_ena));
            check_value("dma_done_irq_o", 32'(dma_done_irq), 32'(m_done));
            check_value("ctrl_word_o", 32'(ctrl_word), 32'(model_ctrl_image()));
            check_value("thresh_count_o", 32'(thresh_count), 32'(exp_thresh));
        end
    endtask

    // Outputs are compared 1 ns after the edge, before new inputs
    task automatic step();
        begin
            @(posedge clk);
            update_model();
            #1;
            check_outputs();
        end
    endtask

    task automatic drive_side_inputs();
        logic [31:0] r;
        begin
            r = $random(seed);
            if (r[2:0] == 3'd0)
                thresh_lvl = ~thresh_lvl;
            if (r[5:3] == 3'd0)
                rx_state[0] = ~rx_state[0];
            if (r[8:6] == 3'd0)
                ovf_lvl = ~ovf_lvl;
            if (r[11:9] == 3'd0)
                full_lvl = ~full_lvl;
            clear_capture = (r[14:12] == 3'd0);
            dma_clr       = (r[17:15] == 3'd0);
            dma_done      = (r[21:18] == 4'd0);
            dma_active    = r[22];
            rx_state[7:1] = r[29:23];
            r = $random(seed);
            fifo_cnt     = r[10:0];
            line_cnt     = r[20:11];
            rx_fifo_data = $random(seed);
        end
    endtask

    task automatic idle_cycle();
        begin
            step();
            drive_side_inputs();
        end
    endtask

    task automatic do_access(input logic we, input logic [9:0] adr,
                             input logic [31:0] dat, input logic [1:0] bstb);
        int waited;
        begin
            wb_cyc   = 1'b1;
            wb_stb   = 1'b1;
            wb_we    = we;
            wb_adr   = adr;
            wb_dat_w = dat;
            wb_bstb  = bstb;
            waited   = 0;
            do
            begin
                step();
                waited++;
            end
            while (!wb_ack && waited < 4);
            if (!wb_ack)
            begin
                protocol_errors++;
                $display("No acknowledge for the access to address %h", adr);
            end
            else
            begin
                assert (waited == 1)
                else
                begin
                    protocol_errors++;
                    $display("Acknowledge came %0d cycles after the strobe, not 1", waited);
                end
                if (!we)
                    check_value("WBs_DAT_o", wb_dat_r, predict_read(adr));
            end
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            drive_side_inputs();
            // Cycle with the acknowledge low again
            idle_cycle();
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [9:0]  adr;
        logic [1:0]  bstb;

        seed = 32'hdb286736;
        value_errors = 0;
        protocol_errors = 0;
        rst = 1'b1;
        {wb_adr, wb_cyc, wb_stb, wb_we, wb_bstb, wb_dat_w} = '0;
        {rx_fifo_data, rx_state, line_cnt, fifo_cnt} = '0;
        {thresh_lvl, ovf_lvl, full_lvl, clear_capture} = '0;
        {dma_done, dma_active, dma_clr} = '0;
        {m_ack, m_cap, m_master, m_flush, m_asel, m_apos} = '0;
        {m_int_en, m_sts, m_fsize, m_tsel} = '0;
        {m_dma_ena, m_done_en, m_done} = '0;
        {thr_h, frm_h, ovf_h, full_h} = '0;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Whole map after reset, plus two unmapped addresses
        for (int a = 0; a < 8; a++)
            do_access(1'b0, 10'(a), 32'd0, 2'b11);
        do_access(1'b0, 10'h008, 32'd0, 2'b11);
        do_access(1'b0, 10'h3ff, 32'd0, 2'b11);

        for (int n = 0; n < NUM_OPS; n++)
        begin
            r = $random(seed);
            if (r[3:0] == 4'd0)
                adr = r[27:18];
            else if (r[9:8] == 2'd0)
                adr = 10'(vga_bus_pkg::CONTROL_ADDR);
            else if (r[9:8] == 2'd1)
                adr = 10'(vga_bus_pkg::DMA_CONTROL_ADDR);
            else
                adr = {7'd0, r[6:4]};
            bstb = (r[11:10] == 2'd0) ? 2'b10 : {r[15], 1'b1};
            if (r[12])
                do_access(1'b1, adr, $random(seed), bstb);
            else
                do_access(1'b0, adr, 32'd0, bstb);
            repeat (r[14:13]) idle_cycle();
        end

        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/vga_rx_reg_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_rx_reg_top #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire                             WBs_CLK_i,
    input  wire                             WBs_RST_i,
    input  wire [ADDR_WIDTH-1:0]            WBs_ADR_i,
    input  wire                             WBs_CYC_i,
    input  wire [1:0]                       WBs_BYTE_STB_i,
    input  wire                             WBs_WE_i,
    input  wire                             WBs_STB_i,
    input  wire vga_bus_pkg::bus_data_t     WBs_DAT_i,
    input  wire vga_bus_pkg::bus_data_t     rx_fifo_data_i,
    input  wire vga_field_pkg::rx_state_t   rx_state_i,
    input  wire vga_field_pkg::line_count_t rcvd_line_cnt_i,
    input  wire vga_field_pkg::fifo_count_t fifo_count_i,
    input  wire                             thresh_reached_i,
    input  wire                             overflow_i,
    input  wire                             fifo_full_i,
    input  wire                             clear_capture_i,
    input  wire                             dma_done_i,
    input  wire                             dma_active_i,
    input  wire                             dma_clr_i,
    output vga_bus_pkg::bus_data_t          WBs_DAT_o,
    output logic                            WBs_ACK_o,
    output logic                            vga_irq_o,
    output vga_field_pkg::ctrl_word_t       ctrl_word_o,
    output vga_field_pkg::line_count_t      thresh_count_o,
    output logic                            fifo_flush_o,
    output logic                            dma_ena_o,
    output logic                            dma_done_irq_o
);

    logic       ctrl_wr;
    logic       dma_wr;
    logic       thresh_evt;
    logic       frame_evt;
    logic       overflow_evt;
    logic       full_evt;
    logic [3:0] int_en;
    logic       master_en;
    logic [3:0] status;
    logic       done_irq_en;

    // ----------------------------------------
    // Bus decode and events
    // ----------------------------------------
    vga_reg_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .WBs_CLK_i  (WBs_CLK_i),
        .WBs_RST_i  (WBs_RST_i),
        .adr_i      (WBs_ADR_i),
        .cyc_i      (WBs_CYC_i),
        .stb_i      (WBs_STB_i),
        .we_i       (WBs_WE_i),
        .byte_stb_i (WBs_BYTE_STB_i),
        .ack_o      (WBs_ACK_o),
        .ctrl_wr_o  (ctrl_wr),
        .dma_wr_o   (dma_wr)
    );

    vga_event_detect u_events (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .thresh_i       (thresh_reached_i),
        .frame_done_i   (rx_state_i[vga_field_pkg::RX_FRAME_DONE_BIT]),
        .overflow_i     (overflow_i),
        .fifo_full_i    (fifo_full_i),
        .thresh_evt_o   (thresh_evt),
        .frame_evt_o    (frame_evt),
        .overflow_evt_o (overflow_evt),
        .full_evt_o     (full_evt)
    );

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    vga_ctrl_regs u_ctrl (
        .WBs_CLK_i       (WBs_CLK_i),
        .WBs_RST_i       (WBs_RST_i),
        .ctrl_wr_i       (ctrl_wr),
        .wdata_i         (WBs_DAT_i),
        .clear_capture_i (clear_capture_i),
        .ctrl_word_o     (ctrl_word_o),
        .flush_o         (fifo_flush_o),
        .thresh_count_o  (thresh_count_o),
        .int_en_o        (int_en),
        .master_en_o     (master_en)
    );

    vga_irq_status u_irq (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .ctrl_wr_i      (ctrl_wr),
        .wdata_i        (WBs_DAT_i),
        .thresh_evt_i   (thresh_evt),
        .frame_evt_i    (frame_evt),
        .overflow_evt_i (overflow_evt),
        .full_evt_i     (full_evt),
        .int_en_i       (int_en),
        .master_en_i    (master_en),
        .status_o       (status),
        .irq_o          (vga_irq_o)
    );

    vga_dma_ctrl u_dma (
        .WBs_CLK_i     (WBs_CLK_i),
        .WBs_RST_i     (WBs_RST_i),
        .dma_wr_i      (dma_wr),
        .wdata_i       (WBs_DAT_i),
        .dma_done_i    (dma_done_i),
        .dma_clr_i     (dma_clr_i),
        .dma_ena_o     (dma_ena_o),
        .done_irq_en_o (done_irq_en),
        .done_irq_o    (dma_done_irq_o)
    );

    // ----------------------------------------
    // Read back
    // ----------------------------------------
    vga_read_mux #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_rmux (
        .adr_i         (WBs_ADR_i),
        .ctrl_word_i   (ctrl_word_o),
        .status_i      (status),
        .fifo_count_i  (fifo_count_i),
        .line_count_i  (rcvd_line_cnt_i),
        .dma_ena_i     (dma_ena_o),
        .done_irq_en_i (done_irq_en),
        .done_irq_i    (dma_done_irq_o),
        .dma_active_i  (dma_active_i),
        .rx_state_i    (rx_state_i),
        .rx_data_i     (rx_fifo_data_i),
        .rdata_o       (WBs_DAT_o)
    );

endmodule

`default_nettype wire

//--- rtl/vga_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module vga_read_mux #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire [ADDR_WIDTH-1:0]            adr_i,
    input  wire vga_field_pkg::ctrl_word_t  ctrl_word_i,
    input  wire [3:0]                       status_i,
    input  wire vga_field_pkg::fifo_count_t fifo_count_i,
    input  wire vga_field_pkg::line_count_t line_count_i,
    input  wire                             dma_ena_i,
    input  wire                             done_irq_en_i,
    input  wire                             done_irq_i,
    input  wire                             dma_active_i,
    input  wire vga_field_pkg::rx_state_t   rx_state_i,
    input  wire vga_bus_pkg::bus_data_t     rx_data_i,
    output vga_bus_pkg::bus_data_t          rdata_o
);

    vga_field_pkg::thresh_sel_t thresh_sel;
    vga_bus_pkg::bus_data_t     dma_ctrl_word;

    assign thresh_sel = ctrl_word_i[vga_field_pkg::THRESH_SEL_LSB +: 2];

    always_comb
    begin
        dma_ctrl_word = '0;
        dma_ctrl_word[vga_field_pkg::DMA_ENA_BIT]     = dma_ena_i;
        dma_ctrl_word[vga_field_pkg::DMA_DONE_EN_BIT] = done_irq_en_i;
        dma_ctrl_word[vga_field_pkg::DMA_DONE_BIT]    = done_irq_i;
    end

    // Read data valid while ack is high
    always_comb
    begin
        case (adr_i)
            ADDR_WIDTH'(vga_bus_pkg::STATUS_ADDR):
                rdata_o = vga_bus_pkg::bus_data_t'(status_i);
            ADDR_WIDTH'(vga_bus_pkg::CONTROL_ADDR):
                rdata_o = vga_bus_pkg::bus_data_t'(ctrl_word_i);
            ADDR_WIDTH'(vga_bus_pkg::FIFO_COUNT_ADDR):
                rdata_o = vga_bus_pkg::bus_data_t'(fifo_count_i);
            ADDR_WIDTH'(vga_bus_pkg::LINE_COUNT_ADDR):
                rdata_o = vga_bus_pkg::bus_data_t'(line_count_i);
            ADDR_WIDTH'(vga_bus_pkg::DMA_CONTROL_ADDR):
                rdata_o = dma_ctrl_word;
            ADDR_WIDTH'(vga_bus_pkg::DMA_STATUS_ADDR):
                rdata_o = vga_bus_pkg::bus_data_t'({thresh_sel, dma_active_i, done_irq_i});
            ADDR_WIDTH'(vga_bus_pkg::RX_DATA_ADDR):
                rdata_o = rx_data_i;
            ADDR_WIDTH'(vga_bus_pkg::DEBUG_ADDR):
                rdata_o = vga_bus_pkg::bus_data_t'(rx_state_i);
            default:
                rdata_o = vga_bus_pkg::UNMAPPED_VALUE;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/vga_dma_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vga_dma_ctrl (
    input  wire                         WBs_CLK_i,
    input  wire                         WBs_RST_i,
    input  wire                         dma_wr_i,
    input  wire vga_bus_pkg::bus_data_t wdata_i,
    input  wire                         dma_done_i,
    input  wire                         dma_clr_i,
    output logic                        dma_ena_o,
    output logic                        done_irq_en_o,
    output logic                        done_irq_o
);

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            dma_ena_o     <= 1'b0;
            done_irq_en_o <= 1'b0;
            done_irq_o    <= 1'b0;
        end
        else
        begin
            if (dma_wr_i)
            begin
                dma_ena_o <= wdata_i[vga_field_pkg::DMA_ENA_BIT];
            end
            else if (dma_clr_i)
            begin
                dma_ena_o <= 1'b0;
            end

            if (dma_wr_i)
            begin
                done_irq_en_o <= wdata_i[vga_field_pkg::DMA_DONE_EN_BIT];
            end

            // Done has priority over software
            if (dma_done_i)
            begin
                done_irq_o <= 1'b1;
            end
            else if (dma_wr_i)
            begin
                done_irq_o <= wdata_i[vga_field_pkg::DMA_DONE_BIT];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/vga_irq_status.sv
`timescale 1ns/1ps
`default_nettype none

module vga_irq_status (
    input  wire                         WBs_CLK_i,
    input  wire                         WBs_RST_i,
    input  wire                         ctrl_wr_i,
    input  wire vga_bus_pkg::bus_data_t wdata_i,
    input  wire                         thresh_evt_i,
    input  wire                         frame_evt_i,
    input  wire                         overflow_evt_i,
    input  wire                         full_evt_i,
    input  wire [3:0]                   int_en_i,
    input  wire                         master_en_i,
    output logic [3:0]                  status_o,
    output logic                        irq_o
);

    logic [3:0] evt;
    logic [3:0] wr_val;

    always_comb
    begin
        evt[vga_field_pkg::STS_FULL]   = full_evt_i;
        evt[vga_field_pkg::STS_OVF]    = overflow_evt_i;
        evt[vga_field_pkg::STS_THRESH] = thresh_evt_i;
        evt[vga_field_pkg::STS_FRAME]  = frame_evt_i;

        // Full and overflow are cleared by any control write
        wr_val[vga_field_pkg::STS_FULL]   = 1'b0;
        wr_val[vga_field_pkg::STS_OVF]    = 1'b0;
        wr_val[vga_field_pkg::STS_THRESH] = wdata_i[vga_field_pkg::THRESH_STS_BIT];
        wr_val[vga_field_pkg::STS_FRAME]  = wdata_i[vga_field_pkg::FRAME_STS_BIT];
    end

    // Sticky bits, an event wins over a write
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            status_o <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (evt[i])
                begin
                    status_o[i] <= 1'b1;
                end
                else if (ctrl_wr_i)
                begin
                    status_o[i] <= wr_val[i];
                end
            end
        end
    end

    assign irq_o = (|(status_o & int_en_i)) & master_en_i;

endmodule

`default_nettype wire

//--- rtl/vga_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vga_ctrl_regs (
    input  wire                      WBs_CLK_i,
    input  wire                      WBs_RST_i,
    input  wire                      ctrl_wr_i,
    input  wire vga_bus_pkg::bus_data_t wdata_i,
    input  wire                      clear_capture_i,
    output vga_field_pkg::ctrl_word_t  ctrl_word_o,
    output logic                     flush_o,
    output vga_field_pkg::line_count_t thresh_count_o,
    output logic [3:0]               int_en_o,
    output logic                     master_en_o
);

    logic                       capture_en;
    logic                       master_en;
    logic                       flush;
    logic [3:0]                 int_en;
    vga_field_pkg::frame_size_t frame_size;
    logic                       alt_byte_sel;
    logic                       alt_byte_pos;
    vga_field_pkg::thresh_sel_t thresh_sel;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            capture_en   <= 1'b0;
            master_en    <= 1'b0;
            flush        <= 1'b0;
            int_en       <= '0;
            frame_size   <= '0;
            alt_byte_sel <= 1'b0;
            alt_byte_pos <= 1'b0;
            thresh_sel   <= '0;
        end
        else if (ctrl_wr_i)
        begin
            capture_en   <= wdata_i[vga_field_pkg::CAPTURE_EN_BIT];
            master_en    <= wdata_i[vga_field_pkg::MASTER_EN_BIT];
            flush        <= wdata_i[vga_field_pkg::FLUSH_BIT];
            int_en       <= wdata_i[vga_field_pkg::INT_EN_LSB +: 4];
            frame_size   <= wdata_i[vga_field_pkg::FRAME_SIZE_LSB +: 2];
            alt_byte_sel <= wdata_i[vga_field_pkg::ALT_BYTE_SEL_BIT];
            alt_byte_pos <= wdata_i[vga_field_pkg::ALT_BYTE_POS_BIT];
            thresh_sel   <= wdata_i[vga_field_pkg::THRESH_SEL_LSB +: 2];
        end
        else
        begin
            // Flush self-clears
            flush <= 1'b0;
            if (clear_capture_i)
            begin
                capture_en <= 1'b0;
            end
        end
    end

    // Control image, status bits 7 and 8 read back as zero
    always_comb
    begin
        ctrl_word_o = '0;
        ctrl_word_o[vga_field_pkg::CAPTURE_EN_BIT]     = capture_en;
        ctrl_word_o[vga_field_pkg::MASTER_EN_BIT]      = master_en;
        ctrl_word_o[vga_field_pkg::FLUSH_BIT]          = flush;
        ctrl_word_o[vga_field_pkg::INT_EN_LSB +: 4]     = int_en;
        ctrl_word_o[vga_field_pkg::FRAME_SIZE_LSB +: 2] = frame_size;
        ctrl_word_o[vga_field_pkg::ALT_BYTE_SEL_BIT]   = alt_byte_sel;
        ctrl_word_o[vga_field_pkg::ALT_BYTE_POS_BIT]   = alt_byte_pos;
        ctrl_word_o[vga_field_pkg::THRESH_SEL_LSB +: 2] = thresh_sel;
    end

    assign thresh_count_o = (thresh_sel == 2'b01) ? vga_field_pkg::THRESH_HALF
                                                  : vga_field_pkg::THRESH_FULL;

    assign flush_o     = flush;
    assign int_en_o    = int_en;
    assign master_en_o = master_en;

    // Writes are never back to back on this bus
    flush_one_cycle: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        flush_o |=> !flush_o
    );

endmodule

`default_nettype wire

//--- rtl/vga_event_detect.sv
`timescale 1ns/1ps
`default_nettype none

module vga_event_detect (
    input  wire  WBs_CLK_i,
    input  wire  WBs_RST_i,
    input  wire  thresh_i,
    input  wire  frame_done_i,
    input  wire  overflow_i,
    input  wire  fifo_full_i,
    output logic thresh_evt_o,
    output logic frame_evt_o,
    output logic overflow_evt_o,
    output logic full_evt_o
);

    // Bit 0 threshold, bit 1 frame done, bit 2 overflow
    logic [2:0] lvl_r1;
    logic [2:0] lvl_r2;
    logic [2:0] lvl_r3;
    logic [2:0] lvl_rise;

    logic       full_r1;
    logic       full_r2;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            lvl_r1  <= '0;
            lvl_r2  <= '0;
            lvl_r3  <= '0;
            full_r1 <= 1'b0;
            full_r2 <= 1'b0;
        end
        else
        begin
            // Two synchronizer stages, then the edge delay
            lvl_r1  <= {overflow_i, frame_done_i, thresh_i};
            lvl_r2  <= lvl_r1;
            lvl_r3  <= lvl_r2;
            // FIFO full is already in this clock domain
            full_r1 <= fifo_full_i;
            full_r2 <= full_r1;
        end
    end

    assign lvl_rise = lvl_r2 & ~lvl_r3;

    assign thresh_evt_o   = lvl_rise[0];
    assign frame_evt_o    = lvl_rise[1];
    assign overflow_evt_o = lvl_rise[2];
    assign full_evt_o     = full_r1 & ~full_r2;

endmodule

`default_nettype wire

//--- rtl/vga_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module vga_reg_decode #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire                  WBs_CLK_i,
    input  wire                  WBs_RST_i,
    input  wire [ADDR_WIDTH-1:0] adr_i,
    input  wire                  cyc_i,
    input  wire                  stb_i,
    input  wire                  we_i,
    input  wire [1:0]            byte_stb_i,
    output logic                 ack_o,
    output logic                 ctrl_wr_o,
    output logic                 dma_wr_o
);

    logic access;
    logic wr_qual;

    // New access only while ack is low
    assign access  = cyc_i & stb_i & ~ack_o;
    assign wr_qual = access & we_i & byte_stb_i[0];

    assign ctrl_wr_o = wr_qual & (adr_i == ADDR_WIDTH'(vga_bus_pkg::CONTROL_ADDR));
    assign dma_wr_o  = wr_qual & (adr_i == ADDR_WIDTH'(vga_bus_pkg::DMA_CONTROL_ADDR));

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ack_o <= 1'b0;
        end
        else
        begin
            ack_o <= access;
        end
    end

    // Every access takes two cycles
    ack_single_cycle: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        ack_o |=> !ack_o
    );

endmodule

`default_nettype wire

//--- rtl/vga_field_pkg.sv
`default_nettype none

package vga_field_pkg;

    typedef logic [9:0]  line_count_t;
    typedef logic [10:0] fifo_count_t;
    typedef logic [7:0]  rx_state_t;
    typedef logic [15:0] ctrl_word_t;
    typedef logic [1:0]  frame_size_t;
    typedef logic [1:0]  thresh_sel_t;

    // Receiver state word
    localparam int RX_FRAME_DONE_BIT = 0;

    // ----------------------------------------
    // Control register fields
    // ----------------------------------------
    localparam int CAPTURE_EN_BIT   = 0;
    localparam int MASTER_EN_BIT    = 1;
    localparam int FLUSH_BIT        = 2;
    // Four enables, same order as the status bits
    localparam int INT_EN_LSB       = 3;
    localparam int THRESH_STS_BIT   = 7;
    localparam int FRAME_STS_BIT    = 8;
    localparam int FRAME_SIZE_LSB   = 9;
    localparam int ALT_BYTE_SEL_BIT = 11;
    localparam int ALT_BYTE_POS_BIT = 12;
    localparam int THRESH_SEL_LSB   = 13;

    // Status bit order
    localparam int STS_FULL   = 0;
    localparam int STS_OVF    = 1;
    localparam int STS_THRESH = 2;
    localparam int STS_FRAME  = 3;

    // ----------------------------------------
    // DMA control fields
    // ----------------------------------------
    localparam int DMA_ENA_BIT     = 0;
    localparam int DMA_DONE_EN_BIT = 1;
    localparam int DMA_DONE_BIT    = 2;

    // Line threshold counts
    localparam line_count_t THRESH_FULL = 10'd960;
    localparam line_count_t THRESH_HALF = 10'd480;

endpackage

`default_nettype wire

//--- rtl/vga_bus_pkg.sv
`default_nettype none

package vga_bus_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] bus_data_t;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [4:0] STATUS_ADDR      = 5'h0;
    localparam logic [4:0] CONTROL_ADDR     = 5'h1;
    localparam logic [4:0] FIFO_COUNT_ADDR  = 5'h2;
    localparam logic [4:0] LINE_COUNT_ADDR  = 5'h3;
    localparam logic [4:0] DMA_CONTROL_ADDR = 5'h4;
    localparam logic [4:0] DMA_STATUS_ADDR  = 5'h5;
    localparam logic [4:0] RX_DATA_ADDR     = 5'h6;
    localparam logic [4:0] DEBUG_ADDR       = 5'h7;

    // Returned for any address outside the map
    localparam bus_data_t UNMAPPED_VALUE = 32'hC0CDEFAC;

endpackage

`default_nettype wire
